// ==== rtl/align_macros.svh ====
`ifndef ALIGN_MACROS_SVH
`define ALIGN_MACROS_SVH

// Cache line geometry
`define ALIGN_LINE_BYTES   16
`define ALIGN_OFFSET_BITS  4

// TLB size
`define ALIGN_TLB_ENTRIES  8
`define ALIGN_TLB_IDX_BITS 3

// Address widths
`define ALIGN_VADDR_BITS   32
`define ALIGN_PAGE_BITS    12
`define ALIGN_PFN_BITS     3

`endif

// ==== rtl/align_pkg.sv ====
`default_nettype none
`include "align_macros.svh"

package align_pkg;

    typedef logic [`ALIGN_VADDR_BITS-1:0]                 vaddr_t;
    typedef logic [`ALIGN_PFN_BITS+`ALIGN_PAGE_BITS-1:0]  paddr_t;
    typedef logic [`ALIGN_VADDR_BITS-`ALIGN_PAGE_BITS-1:0] vpn_t;
    typedef logic [`ALIGN_PFN_BITS-1:0]                   pfn_t;
    typedef logic [`ALIGN_LINE_BYTES*8-1:0]               line_data_t;
    typedef logic [`ALIGN_LINE_BYTES-1:0]                 byte_mask_t;
    // 0..3 encode 1, 2, 4 and 8 bytes
    typedef logic [1:0]                                   size_code_t;
    typedef logic [`ALIGN_OFFSET_BITS:0]                  byte_count_t;

    typedef struct packed {
        vaddr_t     vaddr;
        size_code_t size;
        logic       rd;
        logic       wr;
        logic       from_bus;
        line_data_t data;
        logic       valid;
    } mem_req_t;

    typedef struct packed {
        vpn_t vpn;
        pfn_t pfn;
        logic valid;
        logic present;
        logic rw;
        logic pcd;
    } tlb_entry_t;

    typedef struct packed {
        vaddr_t     vaddr;
        paddr_t     paddr;
        byte_mask_t mask;
        line_data_t data;
        logic       rd;
        logic       wr;
        logic       from_bus;
        logic       valid;
    } line_part_t;

endpackage

`default_nettype wire

// ==== rtl/line_splitter.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "align_macros.svh"

module line_splitter (
    input  align_pkg::mem_req_t    req,
    output align_pkg::vaddr_t      second_vaddr,
    output align_pkg::byte_count_t bytes0,
    output align_pkg::byte_count_t bytes1,
    output logic                   split
);
    import align_pkg::*;

    localparam byte_count_t line_bytes = byte_count_t'(`ALIGN_LINE_BYTES);

    logic [`ALIGN_OFFSET_BITS-1:0] offset;
    byte_count_t size_bytes;
    byte_count_t room;
    byte_count_t end_pos;

    assign offset = req.vaddr[`ALIGN_OFFSET_BITS-1:0];

    always_comb begin
        case (req.size)
            2'd0:    size_bytes = byte_count_t'(1);
            2'd1:    size_bytes = byte_count_t'(2);
            2'd2:    size_bytes = byte_count_t'(4);
            default: size_bytes = byte_count_t'(8);
        endcase
    end

    // Bytes left in the first line
    assign room    = line_bytes - byte_count_t'(offset);
    assign end_pos = byte_count_t'(offset) + size_bytes;
    assign split   = (end_pos > line_bytes) && !req.from_bus;

    // Bus fills always take the whole line
    always_comb begin
        if (req.from_bus) begin
            bytes0 = line_bytes;
        end else if (size_bytes < room) begin
            bytes0 = size_bytes;
        end else begin
            bytes0 = room;
        end
    end

    assign bytes1 = split ? end_pos - line_bytes : '0;

    assign second_vaddr = {req.vaddr[$bits(vaddr_t)-1:`ALIGN_OFFSET_BITS],
                           `ALIGN_OFFSET_BITS'(0)} + vaddr_t'(`ALIGN_LINE_BYTES);

endmodule

`default_nettype wire

// ==== rtl/byte_mask_gen.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "align_macros.svh"

module byte_mask_gen (
    input  logic [`ALIGN_OFFSET_BITS-1:0] offset,
    input  align_pkg::byte_count_t        bytes0,
    input  align_pkg::byte_count_t        bytes1,
    input  logic                          from_bus,
    output align_pkg::byte_mask_t         mask0,
    output align_pkg::byte_mask_t         mask1
);
    import align_pkg::*;

    // Run of n ones from lane 0, n may be a full line
    function automatic byte_mask_t low_ones(byte_count_t n);
        logic [$bits(byte_mask_t):0] run;
        run = ({{$bits(byte_mask_t){1'b0}}, 1'b1} << n) - 1'b1;
        return run[$bits(byte_mask_t)-1:0];
    endfunction

    byte_mask_t run0;
    byte_mask_t run1;

    assign run0 = low_ones(bytes0);
    assign run1 = low_ones(bytes1);

    // bytes0 never exceeds the room above offset, so no lanes fall off
    assign mask0 = from_bus ? '1 : run0 << offset;
    assign mask1 = from_bus ? '0 : run1;

    // Split sizes from the splitter must add up to one access of at most 8 bytes
    mask_span_ok: assert final (from_bus
                                || ($countones(mask0) + $countones(mask1) <= 8))
        else $error("byte masks cover more than 8 lanes");

endmodule

`default_nettype wire

// ==== rtl/data_rotator.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "align_macros.svh"

module data_rotator (
    input  align_pkg::line_data_t         data,
    input  logic [`ALIGN_OFFSET_BITS-1:0] offset,
    input  align_pkg::byte_count_t        bytes0,
    input  logic                          from_bus,
    output align_pkg::line_data_t         data0,
    output align_pkg::line_data_t         data1
);
    import align_pkg::*;

    localparam int line_bits = $bits(line_data_t);

    logic [2*line_bits-1:0] doubled;
    logic [2*line_bits-1:0] shifted;
    line_data_t             remainder;

    // Rotate left by offset lanes using a doubled copy
    assign doubled = {data, data};
    assign shifted = doubled << {offset, 3'b000};

    // Bytes that did not fit in part 0 move down to lane 0
    assign remainder = data >> {bytes0, 3'b000};

    assign data0 = from_bus ? data : shifted[2*line_bits-1:line_bits];
    assign data1 = from_bus ? '0 : remainder;

endmodule

`default_nettype wire

// ==== rtl/tlb_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "align_macros.svh"

module tlb_lookup (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           wr,
    input  logic [`ALIGN_TLB_IDX_BITS-1:0] idx,
    input  align_pkg::tlb_entry_t          entry,
    input  align_pkg::vaddr_t              vaddr0,
    input  align_pkg::vaddr_t              vaddr1,
    input  logic                           en1,
    input  logic                           write,
    output align_pkg::pfn_t                pfn0,
    output align_pkg::pfn_t                pfn1,
    output logic                           hit0,
    output logic                           hit1,
    output logic                           prot0,
    output logic                           prot1,
    output logic                           pcd0,
    output logic                           pcd1
);
    import align_pkg::*;

    tlb_entry_t                    entries [`ALIGN_TLB_ENTRIES];
    vpn_t                          vpn0;
    vpn_t                          vpn1;
    tlb_entry_t                    sel0;
    tlb_entry_t                    sel1;
    logic [`ALIGN_TLB_ENTRIES-1:0] same_vpn0;

    function automatic logic usable(tlb_entry_t e, vpn_t vpn);
        return e.valid && e.present && (e.vpn == vpn);
    endfunction

    // Lookups in the write cycle still see the old entry
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `ALIGN_TLB_ENTRIES; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else if (wr) begin
            entries[idx] <= entry;
        end
    end

    assign vpn0 = vaddr0[$bits(vaddr_t)-1:`ALIGN_PAGE_BITS];
    assign vpn1 = vaddr1[$bits(vaddr_t)-1:`ALIGN_PAGE_BITS];

    // At most one entry matches, so OR-ing the matches selects it
    always_comb begin
        sel0 = '0;
        sel1 = '0;
        for (int i = 0; i < `ALIGN_TLB_ENTRIES; i++) begin
            same_vpn0[i] = entries[i].valid && (entries[i].vpn == vpn0);
            if (usable(entries[i], vpn0)) begin
                sel0 = sel0 | entries[i];
            end
            if (usable(entries[i], vpn1)) begin
                sel1 = sel1 | entries[i];
            end
        end
    end

    assign hit0  = sel0.valid;
    assign pfn0  = sel0.pfn;
    assign prot0 = sel0.valid && write && !sel0.rw;
    assign pcd0  = sel0.valid && sel0.pcd;

    // Disabled port reads as a clean hit
    assign hit1  = en1 ? sel1.valid : 1'b1;
    assign pfn1  = sel1.pfn;
    assign prot1 = en1 && sel1.valid && write && !sel1.rw;
    assign pcd1  = en1 && sel1.valid && sel1.pcd;

    unique_vpn0: assert property (@(posedge clk) disable iff (reset) $onehot0(same_vpn0))
        else $error("two valid TLB entries share a vpn");

endmodule

`default_nettype wire

// ==== rtl/access_align_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "align_macros.svh"

module access_align_ctrl (
    input  logic                  clk,
    input  logic                  reset,
    input  align_pkg::mem_req_t   req,
    input  logic                  split,
    input  align_pkg::vaddr_t     second_vaddr,
    input  align_pkg::byte_mask_t mask0,
    input  align_pkg::byte_mask_t mask1,
    input  align_pkg::line_data_t data0,
    input  align_pkg::line_data_t data1,
    input  align_pkg::pfn_t       pfn0,
    input  align_pkg::pfn_t       pfn1,
    input  logic                  hit0,
    input  logic                  hit1,
    input  logic                  prot0,
    input  logic                  prot1,
    input  logic                  pcd0,
    input  logic                  pcd1,
    output align_pkg::line_part_t part0,
    output align_pkg::line_part_t part1,
    output logic                  need_second,
    output logic                  tlb_miss,
    output logic                  tlb_hit,
    output logic                  prot_fault,
    output logic                  pcd
);
    import align_pkg::*;

    line_part_t part0_d;
    line_part_t part1_d;
    line_part_t part0_q;
    line_part_t part1_q;
    logic       miss_d;
    logic       fault_d;
    logic       abort;
    logic       valid0_q;
    logic       valid1_q;

    assign miss_d  = req.valid && !(hit0 && hit1);
    assign fault_d = req.valid && (prot0 || prot1);
    assign abort   = miss_d || fault_d;

    always_comb begin
        part0_d.vaddr    = req.vaddr;
        part0_d.paddr    = {pfn0, req.vaddr[`ALIGN_PAGE_BITS-1:0]};
        part0_d.mask     = mask0;
        part0_d.data     = data0;
        part0_d.rd       = req.rd;
        part0_d.wr       = req.wr;
        part0_d.from_bus = req.from_bus;
        part0_d.valid    = req.valid && !abort;

        part1_d.vaddr    = second_vaddr;
        part1_d.paddr    = {pfn1, second_vaddr[`ALIGN_PAGE_BITS-1:0]};
        part1_d.mask     = mask1;
        part1_d.data     = data1;
        part1_d.rd       = req.rd;
        part1_d.wr       = req.wr;
        part1_d.from_bus = req.from_bus;
        part1_d.valid    = req.valid && split && !abort;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid0_q   <= 1'b0;
            valid1_q   <= 1'b0;
            tlb_miss   <= 1'b0;
            tlb_hit    <= 1'b0;
            prot_fault <= 1'b0;
            pcd        <= 1'b0;
        end else begin
            valid0_q   <= part0_d.valid;
            valid1_q   <= part1_d.valid;
            tlb_miss   <= miss_d;
            tlb_hit    <= req.valid && hit0 && hit1;
            prot_fault <= fault_d;
            pcd        <= req.valid && (pcd0 || pcd1);
        end
    end

    // Line payload
    always_ff @(posedge clk) begin
        part0_q <= part0_d;
        part1_q <= part1_d;
    end

    always_comb begin
        part0       = part0_q;
        part0.valid = valid0_q;
        part1       = part1_q;
        part1.valid = valid1_q;
    end

    assign need_second = valid1_q;

    part1_needs_part0: assert property (@(posedge clk) disable iff (reset)
        part1.valid |-> part0.valid)
        else $error("second part valid without first part");

    miss_hit_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(tlb_miss && tlb_hit))
        else $error("tlb_miss and tlb_hit both set");

endmodule

`default_nettype wire

// ==== rtl/access_align.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "align_macros.svh"

module access_align (
    input  logic                           clk,
    input  logic                           reset,
    input  align_pkg::mem_req_t            req,
    input  logic                           tlb_wr,
    input  logic [`ALIGN_TLB_IDX_BITS-1:0] tlb_idx,
    input  align_pkg::tlb_entry_t          tlb_entry,
    output align_pkg::line_part_t          part0,
    output align_pkg::line_part_t          part1,
    output logic                           need_second,
    output logic                           tlb_miss,
    output logic                           tlb_hit,
    output logic                           prot_fault,
    output logic                           pcd
);
    import align_pkg::*;

    vaddr_t      second_vaddr;
    byte_count_t bytes0;
    byte_count_t bytes1;
    logic        split;
    byte_mask_t  mask0;
    byte_mask_t  mask1;
    line_data_t  data0;
    line_data_t  data1;
    pfn_t        pfn0;
    pfn_t        pfn1;
    logic        hit0;
    logic        hit1;
    logic        prot0;
    logic        prot1;
    logic        pcd0;
    logic        pcd1;

    line_splitter u_splitter (
        .req          (req),
        .second_vaddr (second_vaddr),
        .bytes0       (bytes0),
        .bytes1       (bytes1),
        .split        (split)
    );

    byte_mask_gen u_mask (
        .offset   (req.vaddr[`ALIGN_OFFSET_BITS-1:0]),
        .bytes0   (bytes0),
        .bytes1   (bytes1),
        .from_bus (req.from_bus),
        .mask0    (mask0),
        .mask1    (mask1)
    );

    data_rotator u_rotator (
        .data     (req.data),
        .offset   (req.vaddr[`ALIGN_OFFSET_BITS-1:0]),
        .bytes0   (bytes0),
        .from_bus (req.from_bus),
        .data0    (data0),
        .data1    (data1)
    );

    // Port 1 only matters for a split access
    tlb_lookup u_tlb (
        .clk    (clk),
        .reset  (reset),
        .wr     (tlb_wr),
        .idx    (tlb_idx),
        .entry  (tlb_entry),
        .vaddr0 (req.vaddr),
        .vaddr1 (second_vaddr),
        .en1    (split),
        .write  (req.wr),
        .pfn0   (pfn0),
        .pfn1   (pfn1),
        .hit0   (hit0),
        .hit1   (hit1),
        .prot0  (prot0),
        .prot1  (prot1),
        .pcd0   (pcd0),
        .pcd1   (pcd1)
    );

    access_align_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .split        (split),
        .second_vaddr (second_vaddr),
        .mask0        (mask0),
        .mask1        (mask1),
        .data0        (data0),
        .data1        (data1),
        .pfn0         (pfn0),
        .pfn1         (pfn1),
        .hit0         (hit0),
        .hit1         (hit1),
        .prot0        (prot0),
        .prot1        (prot1),
        .pcd0         (pcd0),
        .pcd1         (pcd1),
        .part0        (part0),
        .part1        (part1),
        .need_second  (need_second),
        .tlb_miss     (tlb_miss),
        .tlb_hit      (tlb_hit),
        .prot_fault   (prot_fault),
        .pcd          (pcd)
    );

endmodule

`default_nettype wire

// ==== testbench/access_align_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "align_macros.svh"

module access_align_tb;
    import align_pkg::*;

    localparam int num_requests = 400;
    // Reset, TLB fill and requests take about 420 cycles
    localparam int cycle_limit = 600;

    typedef struct packed {
        line_part_t p0;
        line_part_t p1;
        logic       miss;
        logic       hit;
        logic       fault;
        logic       pcd;
    } expect_t;

    logic       clk;
    logic       reset;
    mem_req_t   req;
    logic       tlb_wr;
    logic [2:0] tlb_idx;
    tlb_entry_t tlb_entry;
    line_part_t part0;
    line_part_t part1;
    logic       need_second;
    logic       tlb_miss;
    logic       tlb_hit;
    logic       prot_fault;
    logic       pcd;

    tlb_entry_t  shadow [`ALIGN_TLB_ENTRIES];
    expect_t     exp_q;
    logic        check_en;
    logic [31:0] lfsr_state;
    int          cycles;
    int          value_errors;
    int          flag_errors;

    access_align uut (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .tlb_wr      (tlb_wr),
        .tlb_idx     (tlb_idx),
        .tlb_entry   (tlb_entry),
        .part0       (part0),
        .part1       (part1),
        .need_second (need_second),
        .tlb_miss    (tlb_miss),
        .tlb_hit     (tlb_hit),
        .prot_fault  (prot_fault),
        .pcd         (pcd)
    );

    always #50 clk = ~clk;

    // Galois LFSR, one step per bit
    function automatic logic [127:0] random_bits(input int n);
        logic [127:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits[i] = lfsr_state[0];
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'hA300_0000;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return bits;
    endfunction

    // Usable entry for a page, or all zeros on a miss
    function automatic tlb_entry_t find_page(input vpn_t vpn);
        for (int i = 0; i < `ALIGN_TLB_ENTRIES; i++) begin
            if (shadow[i].valid && shadow[i].present && shadow[i].vpn == vpn) begin
                return shadow[i];
            end
        end
        return '0;
    endfunction

    function automatic expect_t predict(input mem_req_t r);
        expect_t    e;
        int         off;
        int         count;
        int         b0;
        int         b1;
        logic       split;
        logic       abort;
        vaddr_t     va1;
        tlb_entry_t t0;
        tlb_entry_t t1;
        e = '0;
        if (!r.valid) begin
            return e;
        end
        off   = int'(r.vaddr[3:0]);
        count = 1 << r.size;
        split = (off + count > 16) && !r.from_bus;
        b0    = split ? 16 - off : count;
        b1    = split ? off + count - 16 : 0;
        va1   = {r.vaddr[31:4], 4'h0} + 32'd16;
        t0    = find_page(r.vaddr[31:12]);
        t1    = split ? find_page(va1[31:12]) : '0;

        e.hit   = t0.valid && (!split || t1.valid);
        e.miss  = !e.hit;
        e.fault = (t0.valid && r.wr && !t0.rw) || (t1.valid && r.wr && !t1.rw);
        e.pcd   = (t0.valid && t0.pcd) || (t1.valid && t1.pcd);
        abort   = e.miss || e.fault;

        e.p0.vaddr    = r.vaddr;
        e.p0.paddr    = {t0.pfn, r.vaddr[11:0]};
        e.p0.rd       = r.rd;
        e.p0.wr       = r.wr;
        e.p0.from_bus = r.from_bus;
        e.p0.valid    = !abort;
        if (r.from_bus) begin
            e.p0.mask = '1;
            e.p0.data = r.data;
        end else begin
            for (int i = 0; i < b0; i++) begin
                e.p0.mask[off + i] = 1'b1;
            end
            for (int i = 0; i < 16; i++) begin
                e.p0.data[((i + off) % 16) * 8 +: 8] = r.data[i * 8 +: 8];
            end
        end

        e.p1          = e.p0;
        e.p1.vaddr    = va1;
        e.p1.paddr    = {t1.pfn, va1[11:0]};
        e.p1.mask     = '0;
        e.p1.data     = '0;
        e.p1.valid    = split && !abort;
        for (int i = 0; i < b1; i++) begin
            e.p1.mask[i] = 1'b1;
        end
        for (int i = 0; i + b0 < 16; i++) begin
            e.p1.data[i * 8 +: 8] = r.data[(i + b0) * 8 +: 8];
        end
        return e;
    endfunction

    function automatic mem_req_t random_request();
        mem_req_t   r;
        vpn_t       page;
        logic [7:0] line;
        page = vpn_t'(random_bits(4) % 10);
        line = 8'(random_bits(8));
        // Last line of a page often, so splits reach the next page
        if (random_bits(2) == 0) begin
            line = 8'hff;
        end
        r.vaddr    = {page, line, 4'(random_bits(4))};
        r.size     = size_code_t'(random_bits(2));
        r.wr       = 1'(random_bits(1));
        r.rd       = !r.wr;
        r.from_bus = (random_bits(3) == 0);
        r.data     = random_bits(128);
        r.valid    = (random_bits(3) != 0);
        return r;
    endfunction

    task automatic flag_error(input string field);
        flag_errors++;
        $display("CHECK FAILED time=%0d ns: %s mismatch", $time, field);
    endtask

    task automatic value_error(input string field);
        value_errors++;
        $display("CHECK FAILED time=%0d ns: %s mismatch", $time, field);
    endtask

    // TLB copy, a write lands on the clock edge
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `ALIGN_TLB_ENTRIES; i++) begin
                shadow[i].valid <= 1'b0;
            end
        end else if (tlb_wr) begin
            shadow[tlb_idx] <= tlb_entry;
        end
    end

    always @(posedge clk) begin
        exp_q    <= reset ? '0 : predict(req);
        check_en <= 1'b1;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    valid0_ok: assert property (@(posedge clk) check_en |-> part0.valid == exp_q.p0.valid)
        else flag_error("part0.valid");
    valid1_ok: assert property (@(posedge clk) check_en |-> part1.valid == exp_q.p1.valid)
        else flag_error("part1.valid");
    second_ok: assert property (@(posedge clk) check_en |-> need_second == exp_q.p1.valid)
        else flag_error("need_second");
    miss_ok: assert property (@(posedge clk) check_en |-> tlb_miss == exp_q.miss)
        else flag_error("tlb_miss");
    hit_ok: assert property (@(posedge clk) check_en |-> tlb_hit == exp_q.hit)
        else flag_error("tlb_hit");
    fault_ok: assert property (@(posedge clk) check_en |-> prot_fault == exp_q.fault)
        else flag_error("prot_fault");
    pcd_ok: assert property (@(posedge clk) check_en |-> pcd == exp_q.pcd)
        else flag_error("pcd");

    vaddr0_ok: assert property (@(posedge clk)
        (check_en && exp_q.p0.valid) |-> part0.vaddr == exp_q.p0.vaddr)
        else value_error("part0.vaddr");
    paddr0_ok: assert property (@(posedge clk)
        (check_en && exp_q.p0.valid) |-> part0.paddr == exp_q.p0.paddr)
        else value_error("part0.paddr");
    mask0_ok: assert property (@(posedge clk)
        (check_en && exp_q.p0.valid) |-> part0.mask == exp_q.p0.mask)
        else value_error("part0.mask");
    data0_ok: assert property (@(posedge clk)
        (check_en && exp_q.p0.valid) |-> part0.data == exp_q.p0.data)
        else value_error("part0.data");
    kind0_ok: assert property (@(posedge clk) (check_en && exp_q.p0.valid)
        |-> {part0.rd, part0.wr, part0.from_bus}
            == {exp_q.p0.rd, exp_q.p0.wr, exp_q.p0.from_bus})
        else value_error("part0.rd/wr/from_bus");
    vaddr1_ok: assert property (@(posedge clk)
        (check_en && exp_q.p1.valid) |-> part1.vaddr == exp_q.p1.vaddr)
        else value_error("part1.vaddr");
    paddr1_ok: assert property (@(posedge clk)
        (check_en && exp_q.p1.valid) |-> part1.paddr == exp_q.p1.paddr)
        else value_error("part1.paddr");
    mask1_ok: assert property (@(posedge clk)
        (check_en && exp_q.p1.valid) |-> part1.mask == exp_q.p1.mask)
        else value_error("part1.mask");
    data1_ok: assert property (@(posedge clk)
        (check_en && exp_q.p1.valid) |-> part1.data == exp_q.p1.data)
        else value_error("part1.data");
    kind1_ok: assert property (@(posedge clk) (check_en && exp_q.p1.valid)
        |-> {part1.rd, part1.wr, part1.from_bus}
            == {exp_q.p1.rd, exp_q.p1.wr, exp_q.p1.from_bus})
        else value_error("part1.rd/wr/from_bus");

    initial begin
        tlb_entry_t e;
        clk          = 1'b0;
        reset        = 1'b1;
        req          = '0;
        tlb_wr       = 1'b0;
        tlb_idx      = '0;
        tlb_entry    = '0;
        exp_q        = '0;
        check_en     = 1'b0;
        cycles       = 0;
        value_errors = 0;
        flag_errors  = 0;
        lfsr_state   = 32'h8028_773c;

        repeat (5) @(posedge clk);
        #5;
        reset = 1'b0;

        // Page i maps to a frame that differs from i
        for (int i = 0; i < `ALIGN_TLB_ENTRIES; i++) begin
            @(posedge clk);
            #5;
            e.vpn     = vpn_t'(i);
            e.pfn     = pfn_t'(i) ^ 3'b101;
            e.valid   = 1'b1;
            e.present = 1'(random_bits(1));
            e.rw      = 1'(random_bits(1));
            e.pcd     = 1'(random_bits(1));
            tlb_wr    = 1'b1;
            tlb_idx   = 3'(i);
            tlb_entry = e;
        end
        @(posedge clk);
        #5;
        tlb_wr = 1'b0;

        for (int n = 0; n < num_requests; n++) begin
            @(posedge clk);
            #5;
            req = random_request();
        end
        @(posedge clk);
        #5;
        req = '0;
        repeat (3) @(posedge clk);
        #1;

        $display("Errors: %0d flag, %0d value", flag_errors, value_errors);
        if (flag_errors + value_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== access_align.f ====
+incdir+rtl
rtl/align_pkg.sv
rtl/line_splitter.sv
rtl/byte_mask_gen.sv
rtl/data_rotator.sv
rtl/tlb_lookup.sv
rtl/access_align_ctrl.sv
rtl/access_align.sv
testbench/access_align_tb.sv

// ==== Bender.yml ====
package:
  name: access_align

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/align_pkg.sv
      - rtl/line_splitter.sv
      - rtl/byte_mask_gen.sv
      - rtl/data_rotator.sv
      - rtl/tlb_lookup.sv
      - rtl/access_align_ctrl.sv
      - rtl/access_align.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/access_align_tb.sv
